/* logic/lsu_addrcheck_defines.svh */
`ifndef LSU_ADDRCHECK_DEFINES_SVH
`define LSU_ADDRCHECK_DEFINES_SVH

// ****************************************
// Memory map
// ****************************************
`define LSU_DCCM_SADR    32'hF004_0000   // Aligned to its size
`define LSU_DCCM_SIZE    32'h0001_0000   // 64 KiB
`define LSU_DCCM_REGION  4'hF

`define LSU_PIC_SADR     32'hE000_0000
`define LSU_PIC_SIZE     32'h0000_8000   // 32 KiB
`define LSU_PIC_REGION   4'hE

// ****************************************
// Data access windows
// ****************************************
`define LSU_DA_ENABLE0   1'b1
`define LSU_DA_ADDR0     32'h0000_0000   // 0x0000_0000 .. 0x0FFF_FFFF
`define LSU_DA_MASK0     32'h0FFF_FFFF
`define LSU_DA_ENABLE1   1'b1
`define LSU_DA_ADDR1     32'h8000_0000   // 0x8000_0000 .. 0xBFFF_FFFF
`define LSU_DA_MASK1     32'h3FFF_FFFF
`define LSU_DA_ENABLE2   1'b0
`define LSU_DA_ADDR2     32'h2000_0000
`define LSU_DA_MASK2     32'h0FFF_FFFF
`define LSU_DA_ENABLE3   1'b0
`define LSU_DA_ADDR3     32'h4000_0000
`define LSU_DA_MASK3     32'h0FFF_FFFF

// Access fault causes
`define LSU_CAUSE_UNMAPPED    4'h2
`define LSU_CAUSE_MPU         4'h3
`define LSU_CAUSE_REGPRED     4'h5
`define LSU_CAUSE_PIC         4'h6
`define LSU_CAUSE_ATOMIC      4'h7
// Misaligned fault causes
`define LSU_CAUSE_REGCROSS    4'h2
`define LSU_CAUSE_SIDEEFFECT  4'h1

`endif

/* logic/lsu_addrcheck_pkg.sv */
`default_nettype none

package lsu_addrcheck_pkg;

   typedef logic [31:0] addr_t;     // Byte address
   typedef logic [3:0]  region_t;   // Upper address nibble
   typedef logic [3:0]  mscause_t;  // Exception cause
   typedef logic [31:0] mrac_t;     // Two bits per region, upper one is side effect

   // Access packet from the AGU
   typedef struct packed {
      logic valid;
      logic by;
      logic half;
      logic word;
      logic atomic;
      logic dma;
   } lsu_pkt_t;

   // Region and range hits computed in dc1
   typedef struct packed {
      logic start_in_dccm;
      logic end_in_dccm;
      logic start_in_pic;
      logic end_in_pic;
      logic start_in_dccm_region;
      logic end_in_dccm_region;
      logic start_in_pic_region;
      logic end_in_pic_region;
      logic base_reg_local;          // rs1 points into DCCM or PIC region
   } region_hits_t;

   // dc2 stage register
   typedef struct packed {
      lsu_pkt_t     pkt;
      addr_t        start_addr;
      addr_t        end_addr;
      region_hits_t hits;
   } dc2_req_t;

   // dc2 result
   typedef struct packed {
      logic     access_fault;
      logic     misaligned_fault;
      logic     is_sideeffects;
      logic     addr_external;
      mscause_t exc_mscause;
   } lsu_fault_t;

endpackage

`default_nettype wire

/* logic/lsu_region_decode.sv */
`default_nettype none

`include "lsu_addrcheck_defines.svh"

module lsu_region_decode (
   input  logic                        clk,
   input  logic                        rst,
   input  lsu_addrcheck_pkg::addr_t    start_addr,
   input  lsu_addrcheck_pkg::addr_t    end_addr,
   input  lsu_addrcheck_pkg::addr_t    rs1,         // Base register of the AGU
   input  lsu_addrcheck_pkg::lsu_pkt_t pkt,

   output logic                        addr_in_dccm_region_dc1,
   output logic                        addr_in_dccm_dc1,
   output logic                        addr_in_pic_dc1,
   output logic                        addr_external_dc1,
   output lsu_addrcheck_pkg::dc2_req_t dc2_req
);

   import lsu_addrcheck_pkg::*;

   localparam addr_t   DCCM_SADR   = `LSU_DCCM_SADR;
   localparam addr_t   DCCM_SIZE   = `LSU_DCCM_SIZE;
   localparam region_t DCCM_REGION = `LSU_DCCM_REGION;
   localparam addr_t   PIC_SADR    = `LSU_PIC_SADR;
   localparam addr_t   PIC_SIZE    = `LSU_PIC_SIZE;
   localparam region_t PIC_REGION  = `LSU_PIC_REGION;

   region_hits_t hits_dc1;
   region_t      rs1_region;
   logic         addr_in_pic_region_dc1;
   dc2_req_t     dc2_req_nxt;

   // Bits above log2(size) must match the base, size is a power of two
   function automatic logic in_range(addr_t addr, addr_t base, addr_t size);
      return ((addr ^ base) & ~(size - 32'd1)) == '0;
   endfunction

   function automatic logic in_region(addr_t addr, region_t region);
      return addr[31:28] == region;
   endfunction

   // ****************************************
   // Range and region checks
   // ****************************************
   assign hits_dc1.start_in_dccm        = in_range(start_addr, DCCM_SADR, DCCM_SIZE);
   assign hits_dc1.end_in_dccm          = in_range(end_addr, DCCM_SADR, DCCM_SIZE);
   assign hits_dc1.start_in_pic         = in_range(start_addr, PIC_SADR, PIC_SIZE);
   assign hits_dc1.end_in_pic           = in_range(end_addr, PIC_SADR, PIC_SIZE);
   assign hits_dc1.start_in_dccm_region = in_region(start_addr, DCCM_REGION);
   assign hits_dc1.end_in_dccm_region   = in_region(end_addr, DCCM_REGION);
   assign hits_dc1.start_in_pic_region  = in_region(start_addr, PIC_REGION);
   assign hits_dc1.end_in_pic_region    = in_region(end_addr, PIC_REGION);

   // Region prediction from the base register, final address is checked in dc2
   assign rs1_region              = rs1[31:28];
   assign addr_in_dccm_region_dc1 = (rs1_region == DCCM_REGION);
   assign addr_in_pic_region_dc1  = (rs1_region == PIC_REGION);
   assign hits_dc1.base_reg_local = addr_in_dccm_region_dc1 | addr_in_pic_region_dc1;

   // Early flags
   assign addr_in_dccm_dc1  = hits_dc1.start_in_dccm & hits_dc1.end_in_dccm;
   assign addr_in_pic_dc1   = hits_dc1.start_in_pic & hits_dc1.end_in_pic;
   assign addr_external_dc1 = ~hits_dc1.base_reg_local;  // Taken from rs1 for timing

   // ****************************************
   // dc2 stage register
   // ****************************************
   assign dc2_req_nxt.pkt        = pkt;
   assign dc2_req_nxt.start_addr = start_addr;
   assign dc2_req_nxt.end_addr   = end_addr;
   assign dc2_req_nxt.hits       = hits_dc1;

   always_ff @(posedge clk) begin
      if (rst) begin
         dc2_req <= '0;
      end else begin
         dc2_req <= dc2_req_nxt;
      end
   end

endmodule

`default_nettype wire

/* logic/lsu_mpu_check.sv */
`default_nettype none

`include "lsu_addrcheck_defines.svh"

module lsu_mpu_check (
   input  lsu_addrcheck_pkg::addr_t start_addr,
   input  lsu_addrcheck_pkg::addr_t end_addr,
   output logic                     non_dccm_ok   // Access falls in a populated window
);

   import lsu_addrcheck_pkg::*;

   localparam int unsigned DA_WINDOWS = 4;

   localparam logic [DA_WINDOWS-1:0] DA_ENABLE = {
      `LSU_DA_ENABLE3, `LSU_DA_ENABLE2, `LSU_DA_ENABLE1, `LSU_DA_ENABLE0
   };

   localparam addr_t DA_ADDR [DA_WINDOWS] = '{
      `LSU_DA_ADDR0, `LSU_DA_ADDR1, `LSU_DA_ADDR2, `LSU_DA_ADDR3
   };

   localparam addr_t DA_MASK [DA_WINDOWS] = '{
      `LSU_DA_MASK0, `LSU_DA_MASK1, `LSU_DA_MASK2, `LSU_DA_MASK3
   };

   logic start_hit;
   logic end_hit;

   // Mask bits are don't care in the compare
   function automatic logic window_hit(addr_t addr);
      logic hit;
      hit = 1'b0;
      for (int i = 0; i < DA_WINDOWS; i++) begin
         hit |= DA_ENABLE[i] & ((addr | DA_MASK[i]) == (DA_ADDR[i] | DA_MASK[i]));
      end
      return hit;
   endfunction

   assign start_hit = window_hit(start_addr);
   assign end_hit   = window_hit(end_addr);

   // No window enabled means the whole space is open
   assign non_dccm_ok = ~(|DA_ENABLE) | (start_hit & end_hit);

endmodule

`default_nettype wire

/* logic/lsu_fault_detect.sv */
`default_nettype none

`include "lsu_addrcheck_defines.svh"

module lsu_fault_detect (
   input  lsu_addrcheck_pkg::dc2_req_t   dc2_req,
   input  lsu_addrcheck_pkg::mrac_t      mrac,      // MRAC CSR
   output lsu_addrcheck_pkg::lsu_fault_t fault
);

   import lsu_addrcheck_pkg::*;

   lsu_pkt_t     pkt;
   region_hits_t hits;
   addr_t        start_addr;
   addr_t        end_addr;
   region_t      start_region;
   region_t      end_region;
   logic [4:0]   csr_idx;

   logic         start_local;
   logic         is_aligned;
   logic         addr_in_dccm;
   logic         addr_in_pic;
   logic         word_aligned;
   logic         non_dccm_ok;

   logic         unmapped_fault;
   logic         mpu_fault;
   logic         regpred_fault;
   logic         pic_fault;
   logic         atomic_fault;
   logic         regcross_fault;
   logic         sideeffect_fault;
   mscause_t     access_cause;
   mscause_t     misaligned_cause;

   assign pkt          = dc2_req.pkt;
   assign hits         = dc2_req.hits;
   assign start_addr   = dc2_req.start_addr;
   assign end_addr     = dc2_req.end_addr;
   assign start_region = start_addr[31:28];
   assign end_region   = end_addr[31:28];

   lsu_mpu_check i_mpu_check (
      .start_addr  (start_addr),
      .end_addr    (end_addr),
      .non_dccm_ok (non_dccm_ok)
   );

   // ****************************************
   // Attributes
   // ****************************************
   assign start_local  = hits.start_in_dccm_region | hits.start_in_pic_region;
   assign csr_idx      = {start_region, 1'b1};               // Upper bit of the region pair
   assign addr_in_dccm = hits.start_in_dccm & hits.end_in_dccm;
   assign addr_in_pic  = hits.start_in_pic & hits.end_in_pic;
   assign word_aligned = (start_addr[1:0] == 2'b00);

   assign fault.is_sideeffects = mrac[csr_idx] & ~start_local;  // Ignored in local regions
   assign fault.addr_external  = ~start_local;

   assign is_aligned = pkt.by |
                       (pkt.half & ~start_addr[0]) |
                       (pkt.word & word_aligned);

   // ****************************************
   // Access faults
   // ****************************************
   // In a local region but outside its range
   assign unmapped_fault = (hits.start_in_dccm_region & ~hits.start_in_dccm) |
                           (hits.end_in_dccm_region & ~hits.end_in_dccm) |
                           (hits.start_in_pic_region & ~hits.start_in_pic) |
                           (hits.end_in_pic_region & ~hits.end_in_pic);

   assign mpu_fault     = ~start_local & ~non_dccm_ok;
   assign regpred_fault = start_local ^ hits.base_reg_local;   // Base and final class differ
   assign pic_fault     = addr_in_pic & (~pkt.word | ~word_aligned);
   assign atomic_fault  = pkt.atomic & (~word_aligned | ~addr_in_dccm);

   assign fault.access_fault = (unmapped_fault | mpu_fault | regpred_fault |
                                pic_fault | atomic_fault) & pkt.valid & ~pkt.dma;

   // Priority order of the causes
   always_comb begin
      if (unmapped_fault) begin
         access_cause = `LSU_CAUSE_UNMAPPED;
      end else if (mpu_fault) begin
         access_cause = `LSU_CAUSE_MPU;
      end else if (regpred_fault) begin
         access_cause = `LSU_CAUSE_REGPRED;
      end else if (pic_fault) begin
         access_cause = `LSU_CAUSE_PIC;
      end else if (atomic_fault) begin
         access_cause = `LSU_CAUSE_ATOMIC;
      end else begin
         access_cause = '0;
      end
   end

   // ****************************************
   // Misaligned faults
   // ****************************************
   // Atomics never take a misaligned fault
   assign regcross_fault   = (start_region != end_region);
   assign sideeffect_fault = fault.is_sideeffects & ~is_aligned & fault.addr_external;

   assign fault.misaligned_fault = (regcross_fault | sideeffect_fault) &
                                   pkt.valid & ~pkt.dma & ~pkt.atomic;

   assign misaligned_cause = regcross_fault ? `LSU_CAUSE_REGCROSS : `LSU_CAUSE_SIDEEFFECT;

   // Misaligned wins over access fault
   always_comb begin
      if (fault.misaligned_fault) begin
         fault.exc_mscause = misaligned_cause;
      end else if (fault.access_fault) begin
         fault.exc_mscause = access_cause;
      end else begin
         fault.exc_mscause = '0;
      end
   end

endmodule

`default_nettype wire

/* logic/lsu_addrcheck.sv */
`default_nettype none

module lsu_addrcheck (
   input  logic                          clk,
   input  logic                          rst,

   input  lsu_addrcheck_pkg::addr_t      start_addr,
   input  lsu_addrcheck_pkg::addr_t      end_addr,
   input  lsu_addrcheck_pkg::addr_t      rs1,
   input  lsu_addrcheck_pkg::lsu_pkt_t   pkt,
   input  lsu_addrcheck_pkg::mrac_t      mrac,

   // Early flags, same cycle as the inputs
   output logic                          addr_in_dccm_region_dc1,
   output logic                          addr_in_dccm_dc1,
   output logic                          addr_in_pic_dc1,
   output logic                          addr_external_dc1,

   // One cycle later
   output lsu_addrcheck_pkg::lsu_fault_t fault_dc2
);

   import lsu_addrcheck_pkg::*;

   dc2_req_t dc2_req;   // dc1 to dc2 pipeline register

   // ****************************************
   // dc1 stage
   // ****************************************
   lsu_region_decode i_region_decode (
      .clk                     (clk),
      .rst                     (rst),
      .start_addr              (start_addr),
      .end_addr                (end_addr),
      .rs1                     (rs1),
      .pkt                     (pkt),
      .addr_in_dccm_region_dc1 (addr_in_dccm_region_dc1),
      .addr_in_dccm_dc1        (addr_in_dccm_dc1),
      .addr_in_pic_dc1         (addr_in_pic_dc1),
      .addr_external_dc1       (addr_external_dc1),
      .dc2_req                 (dc2_req)
   );

   // ****************************************
   // dc2 stage
   // ****************************************
   lsu_fault_detect i_fault_detect (
      .dc2_req (dc2_req),
      .mrac    (mrac),
      .fault   (fault_dc2)
   );

endmodule

`default_nettype wire

/* bench/lsu_addrcheck_assertions.sv */
`default_nettype none

module lsu_addrcheck_assertions (
   input  logic                          clk,
   input  logic                          rst,
   input  lsu_addrcheck_pkg::lsu_pkt_t   pkt,
   input  lsu_addrcheck_pkg::lsu_fault_t fault
);

   import lsu_addrcheck_pkg::*;

   int unsigned fail_count = 0;   // Read by the testbench

   // ****************************************
   // dc2 stage result
   // ****************************************
   // A cause code is present exactly when a fault is reported
   fault_has_cause: assert property (@(posedge clk) disable iff (rst)
      (fault.access_fault || fault.misaligned_fault) == (fault.exc_mscause != '0))
   else begin
      fail_count++;
      $error("Cause code does not match the fault flags");
   end

   // Packet entered dc1 one cycle before its result
   invalid_no_fault: assert property (@(posedge clk) disable iff (rst)
      !$past(pkt.valid) |-> !fault.access_fault && !fault.misaligned_fault)
   else begin
      fail_count++;
      $error("Fault raised for an invalid packet");
   end

   atomic_aligned: assert property (@(posedge clk) disable iff (rst)
      $past(pkt.atomic) |-> !fault.misaligned_fault)
   else begin
      fail_count++;
      $error("Atomic access took a misaligned fault");
   end

endmodule

bind lsu_addrcheck lsu_addrcheck_assertions i_assertions (
   .clk     (clk),
   .rst     (rst),
   .pkt     (pkt),
   .fault   (fault_dc2)
);

`default_nettype wire

/* bench/lsu_addrcheck_tb.sv */
`default_nettype none

`include "lsu_addrcheck_defines.svh"

module lsu_addrcheck_tb;

   import lsu_addrcheck_pkg::*;

   localparam int RESET_CYCLES = 10;
   localparam int N_DIRECTED   = 20;
   localparam int N_RANDOM     = 400;
   localparam int CYCLE_LIMIT  = RESET_CYCLES + N_DIRECTED + N_RANDOM + 20;
   localparam int DRIVE_DELAY  = 2;
   localparam logic [31:0] LFSR_SEED = 32'h01a1a912;
   localparam logic [31:0] LFSR_TAPS = 32'hB4BC_D35C;
   localparam addr_t BASES [8] = '{`LSU_DCCM_SADR, `LSU_PIC_SADR, 32'h0000_0000, 32'h8000_0000,
      32'h5000_0000, 32'h0FFF_FFF0, `LSU_DCCM_SADR + `LSU_DCCM_SIZE - 8,
      `LSU_PIC_SADR + `LSU_PIC_SIZE - 4};

   typedef struct packed {
      addr_t    start_addr;
      addr_t    end_addr;
      addr_t    rs1;
      lsu_pkt_t pkt;
      mrac_t    mrac;
   } stim_t;

   logic       clk;
   logic       rst;
   addr_t      start_addr;
   addr_t      end_addr;
   addr_t      rs1;
   lsu_pkt_t   pkt;
   mrac_t      mrac;
   logic       addr_in_dccm_region_dc1;
   logic       addr_in_dccm_dc1;
   logic       addr_in_pic_dc1;
   logic       addr_external_dc1;
   lsu_fault_t fault_dc2;

   logic [31:0] lfsr;
   mrac_t       csr_value;
   stim_t       stim_q[$];        // Accesses in dc1 and dc2
   stim_t       cur_stim;
   lsu_fault_t  exp_fault;
   logic [3:0]  exp_dc1;
   int          checks = 0;
   int          errors = 0;
   int          cycles = 0;

   lsu_addrcheck i_dut (
      .clk                     (clk),
      .rst                     (rst),
      .start_addr              (start_addr),
      .end_addr                (end_addr),
      .rs1                     (rs1),
      .pkt                     (pkt),
      .mrac                    (mrac),
      .addr_in_dccm_region_dc1 (addr_in_dccm_region_dc1),
      .addr_in_dccm_dc1        (addr_in_dccm_dc1),
      .addr_in_pic_dc1         (addr_in_pic_dc1),
      .addr_external_dc1       (addr_external_dc1),
      .fault_dc2               (fault_dc2)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Galois LFSR, one step per bit
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v    = {v[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
      end
      return v;
   endfunction

   // ****************************************
   // Reference model
   // ****************************************
   function automatic logic in_dccm(input addr_t a);
      return (a & ~(`LSU_DCCM_SIZE - 32'd1)) == `LSU_DCCM_SADR;
   endfunction

   function automatic logic in_pic(input addr_t a);
      return (a & ~(`LSU_PIC_SIZE - 32'd1)) == `LSU_PIC_SADR;
   endfunction

   function automatic logic is_local(input addr_t a);
      return a[31:28] == `LSU_DCCM_REGION || a[31:28] == `LSU_PIC_REGION;
   endfunction

   function automatic logic in_window(input addr_t a);
      addr_t      waddr [4];
      addr_t      wmask [4];
      logic [3:0] en;
      logic       hit;
      waddr = '{`LSU_DA_ADDR0, `LSU_DA_ADDR1, `LSU_DA_ADDR2, `LSU_DA_ADDR3};
      wmask = '{`LSU_DA_MASK0, `LSU_DA_MASK1, `LSU_DA_MASK2, `LSU_DA_MASK3};
      en    = {`LSU_DA_ENABLE3, `LSU_DA_ENABLE2, `LSU_DA_ENABLE1, `LSU_DA_ENABLE0};
      hit   = (en == '0);
      for (int i = 0; i < 4; i++) begin
         if (en[i] && (a & ~wmask[i]) == (waddr[i] & ~wmask[i])) hit = 1'b1;
      end
      return hit;
   endfunction

   // {dccm region, in dccm, in pic, external}
   function automatic logic [3:0] ref_dc1(input stim_t s);
      return {s.rs1[31:28] == `LSU_DCCM_REGION, in_dccm(s.start_addr) && in_dccm(s.end_addr),
              in_pic(s.start_addr) && in_pic(s.end_addr), !is_local(s.rs1)};
   endfunction

   function automatic lsu_fault_t ref_fault(input stim_t s, input mrac_t csr);
      lsu_fault_t f;
      region_t    sr;
      region_t    er;
      logic       word_al;
      logic       aligned;
      logic       active;
      mscause_t   acause;
      sr      = s.start_addr[31:28];
      er      = s.end_addr[31:28];
      word_al = s.start_addr[1:0] == 2'b00;
      aligned = s.pkt.by || (s.pkt.half && !s.start_addr[0]) || (s.pkt.word && word_al);
      active  = s.pkt.valid && !s.pkt.dma;
      f.addr_external  = !is_local(s.start_addr);
      f.is_sideeffects = f.addr_external && csr[2 * sr + 1];
      // Lowest priority first so the higher ones overwrite
      acause = '0;
      if (s.pkt.atomic && (!word_al || !(in_dccm(s.start_addr) && in_dccm(s.end_addr))))
         acause = `LSU_CAUSE_ATOMIC;
      if (in_pic(s.start_addr) && in_pic(s.end_addr) && (!s.pkt.word || !word_al))
         acause = `LSU_CAUSE_PIC;
      if (is_local(s.start_addr) != is_local(s.rs1)) acause = `LSU_CAUSE_REGPRED;
      if (f.addr_external && !(in_window(s.start_addr) && in_window(s.end_addr)))
         acause = `LSU_CAUSE_MPU;
      if ((sr == `LSU_DCCM_REGION && !in_dccm(s.start_addr)) ||
          (er == `LSU_DCCM_REGION && !in_dccm(s.end_addr)) ||
          (sr == `LSU_PIC_REGION && !in_pic(s.start_addr)) ||
          (er == `LSU_PIC_REGION && !in_pic(s.end_addr)))
         acause = `LSU_CAUSE_UNMAPPED;
      f.access_fault     = active && acause != '0;
      f.misaligned_fault = active && !s.pkt.atomic &&
                           (sr != er || (f.is_sideeffects && !aligned && f.addr_external));
      if (f.misaligned_fault)
         f.exc_mscause = (sr != er) ? `LSU_CAUSE_REGCROSS : `LSU_CAUSE_SIDEEFFECT;
      else
         f.exc_mscause = f.access_fault ? acause : '0;
      return f;
   endfunction

   // ****************************************
   // Stimulus
   // ****************************************
   task automatic drive(input stim_t s);
      @(posedge clk);
      #DRIVE_DELAY;
      start_addr = s.start_addr;
      end_addr   = s.end_addr;
      rs1        = s.rs1;
      pkt        = s.pkt;
      mrac       = s.mrac;
      stim_q.push_back(s);
   endtask

   task automatic send(input addr_t start, input int size, input addr_t base,
                       input logic atomic, input logic dma, input logic valid);
      stim_t s;
      s.start_addr = start;
      s.end_addr   = start + size - 1;
      s.rs1        = base;
      s.pkt        = '{valid: valid, by: size == 1, half: size == 2, word: size == 4,
                       atomic: atomic, dma: dma};
      s.mrac       = csr_value;
      drive(s);
   endtask

   task automatic access(input addr_t start, input int size, input addr_t base);
      send(start, size, base, 1'b0, 1'b0, 1'b1);
   endtask

   task automatic idle();
      send('0, 1, '0, 1'b0, 1'b0, 1'b0);
   endtask

   task automatic random_access();
      addr_t      start;
      addr_t      base;
      logic [1:0] size_sel;
      logic       atomic;
      logic       dma;
      logic       valid;
      start     = BASES[take_bits(3)] + take_bits(5);
      size_sel  = take_bits(2);
      base      = (take_bits(3) == 0) ? take_bits(32) : start;   // Sometimes a foreign base
      atomic    = take_bits(3) == 0;
      dma       = take_bits(3) == 0;
      valid     = take_bits(4) != 0;
      csr_value = take_bits(32);
      send(start, (size_sel == 0) ? 1 : (size_sel == 1) ? 2 : 4, base, atomic, dma, valid);
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("ERROR %0t %s: expected %h, got %h", $time, name, expected, actual);
      end
   endtask

   // ****************************************
   // Compare, dc1 now and dc2 one cycle later
   // ****************************************
   always @(negedge clk) begin
      if (stim_q.size() > 0) begin
         cur_stim = stim_q[$];
         exp_dc1  = ref_dc1(cur_stim);
         check_value("addr_in_dccm_region_dc1", exp_dc1[3], addr_in_dccm_region_dc1);
         check_value("addr_in_dccm_dc1", exp_dc1[2], addr_in_dccm_dc1);
         check_value("addr_in_pic_dc1", exp_dc1[1], addr_in_pic_dc1);
         check_value("addr_external_dc1", exp_dc1[0], addr_external_dc1);
         if (stim_q.size() > 1) begin
            exp_fault = ref_fault(stim_q[0], cur_stim.mrac);  // MRAC is read in dc2
            check_value("access_fault", exp_fault.access_fault, fault_dc2.access_fault);
            check_value("misaligned_fault", exp_fault.misaligned_fault,
                        fault_dc2.misaligned_fault);
            check_value("is_sideeffects", exp_fault.is_sideeffects, fault_dc2.is_sideeffects);
            check_value("addr_external", exp_fault.addr_external, fault_dc2.addr_external);
            check_value("exc_mscause", exp_fault.exc_mscause, fault_dc2.exc_mscause);
            void'(stim_q.pop_front());
         end
      end
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles > CYCLE_LIMIT) begin
         $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("Errors found");
         $finish;
      end
   end

   initial begin
      lfsr       = LFSR_SEED;
      csr_value  = '0;
      rst        = 1'b1;
      start_addr = '0;
      end_addr   = '0;
      rs1        = '0;
      pkt        = '0;
      mrac       = '0;
      repeat (RESET_CYCLES - 1) idle();
      @(posedge clk);
      #DRIVE_DELAY;
      rst = 1'b0;

      access(32'hF004_0010, 4, 32'hF004_0000);   // DCCM
      access(32'hE000_0100, 4, 32'hE000_0000);   // PIC
      access(32'hF005_0000, 4, 32'hF000_0000);   // Unmapped
      access(32'hE000_8000, 4, 32'hE000_0000);
      access(32'h5000_0000, 4, 32'h5000_0000);   // MPU
      access(32'h0000_1000, 4, 32'h0000_1000);
      access(32'h9000_0000, 4, 32'h9000_0000);
      access(32'h0000_1000, 4, 32'hF004_0000);   // Region prediction
      access(32'hE000_0100, 2, 32'hE000_0000);   // PIC size and alignment
      access(32'hE000_0102, 4, 32'hE000_0000);
      send(32'h0000_1000, 4, 32'h0000_1000, 1'b1, 1'b0, 1'b1);
      send(32'hF004_0002, 4, 32'hF004_0000, 1'b1, 1'b0, 1'b1);
      send(32'hF004_0008, 4, 32'hF004_0000, 1'b1, 1'b0, 1'b1);
      access(32'h0FFF_FFFE, 4, 32'h0FFF_FFFE);   // Region cross
      csr_value = 32'h1 << 19;                   // Region 9 has side effects
      access(32'h9000_0001, 4, 32'h9000_0000);
      idle();
      csr_value = '0;
      access(32'h9000_0001, 4, 32'h9000_0000);
      idle();
      send(32'h5000_0000, 4, 32'h5000_0000, 1'b0, 1'b1, 1'b1);
      send(32'h0000_1001, 4, 32'h0000_1001, 1'b1, 1'b1, 1'b1);

      repeat (N_RANDOM) random_access();
      idle();
      @(posedge clk);

      $display("Checks: %0d, mismatches: %0d, assertion failures: %0d",
               checks, errors, i_dut.i_assertions.fail_count);
      if (errors == 0 && i_dut.i_assertions.fail_count == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* project.f */
+incdir+logic
logic/lsu_addrcheck_pkg.sv
logic/lsu_region_decode.sv
logic/lsu_mpu_check.sv
logic/lsu_fault_detect.sv
logic/lsu_addrcheck.sv
bench/lsu_addrcheck_assertions.sv
bench/lsu_addrcheck_tb.sv

/* Bender.yml */
package:
  name: lsu_addrcheck

sources:
  - include_dirs:
      - logic
    files:
      - logic/lsu_addrcheck_pkg.sv
      - logic/lsu_region_decode.sv
      - logic/lsu_mpu_check.sv
      - logic/lsu_fault_detect.sv
      - logic/lsu_addrcheck.sv
  - target: test
    include_dirs:
      - logic
    files:
      - bench/lsu_addrcheck_assertions.sv
      - bench/lsu_addrcheck_tb.sv
